// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sources.f --top-module tetris_drop_tb \
        -o tetris_drop_sim &&
./obj_dir/tetris_drop_sim | tee /dev/stderr | grep "Test passed" > /dev/null &&
echo "simulation ok" ||
{ echo "simulation or build failed"; exit 1; }

// ==== source/block_boundary.sv ====
`timescale 1ns/1ps

module block_boundary
        import geom_pkg::*;
        import piece_pkg::*;
(
        input  coord_t       pos_x,
        input  coord_t       pos_y,
        input  piece_cells_u piece,
        output edges_t       edges
);

        // lowest occupied row of each column
        always_comb
        begin
                for (int c = 0; c < 4; c++)
                begin
                        edges.bottom[c] = NO_EDGE;
                        for (int r = 0; r < 4; r++)
                        begin
                                if (piece.cells[4*r + c])
                                        edges.bottom[c] = pos_y + coord_t'(CELL * r);
                        end
                end
        end

        // scan right to left so the leftmost column wins
        always_comb
        begin
                for (int r = 0; r < 4; r++)
                begin
                        edges.left[r] = NO_EDGE;
                        for (int c = 3; c >= 0; c--)
                        begin
                                if (piece.cells[4*r + c])
                                        edges.left[r] = pos_x + coord_t'(CELL * c);
                        end
                end
        end

        // rightmost occupied column
        always_comb
        begin
                for (int r = 0; r < 4; r++)
                begin
                        edges.right[r] = NO_EDGE;
                        for (int c = 0; c < 4; c++)
                        begin
                                if (piece.cells[4*r + c])
                                        edges.right[r] = pos_x + coord_t'(CELL * c);
                        end
                end
        end

endmodule

// ==== source/geom_pkg.sv ====
package geom_pkg;

        // pixel coordinate on the 640x480 screen
        typedef logic [9:0] coord_t;

        localparam coord_t CELL = 10'd20;

        // marks a row or column with no cell
        localparam coord_t NO_EDGE = 10'd1023;

        // field is 10 cells wide
        localparam coord_t FIELD_LEFT = 10'd200;
        localparam coord_t FIELD_RIGHT = 10'd400; // one past last column
        localparam coord_t FIELD_BOTTOM = 10'd480; // one past last row

        localparam coord_t SPAWN_X = 10'd280;
        localparam coord_t SPAWN_Y = 10'd0;

endpackage

// ==== source/move_request.sv ====
`timescale 1ns/1ps

module move_request
        import piece_pkg::*;
(
        input  logic      clk,
        input  logic      arst_n,
        input  buttons_t  buttons,
        input  logic      fall_en,
        output move_cmd_t cmd
);

        buttons_t sync1_q;
        buttons_t sync2_q;
        buttons_t last_q;
        buttons_t press_q;

        logic [FALL_W-1:0] fall_cnt;
        logic fall_tick;
        logic down_req;
        move_cmd_t cmd_next;

        // two-flop synchronizer, then rising edge
        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                begin
                        sync1_q <= '0;
                        sync2_q <= '0;
                        last_q <= '0;
                        press_q <= '0;
                end
                else
                begin
                        sync1_q <= buttons;
                        sync2_q <= sync1_q;
                        last_q <= sync2_q;
                        press_q <= sync2_q & ~last_q;
                end
        end

        // gravity timer
        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                        fall_cnt <= '0;
                else if (!fall_en)
                        fall_cnt <= '0;
                else
                        fall_cnt <= fall_cnt + 1'b1; // wraps every FALL_TICKS
        end

        assign fall_tick = fall_en && (fall_cnt == FALL_W'(FALL_TICKS - 1));

        // down beats left beats right
        always_comb
        begin
                down_req = press_q.down | fall_tick;
                cmd_next.step_down = down_req;
                cmd_next.step_left = press_q.left & ~down_req;
                cmd_next.step_right = press_q.right & ~press_q.left & ~down_req;
        end

        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                        cmd <= '0;
                else
                        cmd <= cmd_next;
        end

endmodule

// ==== source/piece_mover.sv ====
`timescale 1ns/1ps

module piece_mover
        import geom_pkg::*;
        import piece_pkg::*;
(
        input  logic         clk,
        input  logic         arst_n,
        input  move_cmd_t    cmd,
        output coord_t       pos_x,
        output coord_t       pos_y,
        output piece_cells_u piece,
        output shape_idx_t   shape_idx,
        output logic         landing
);

        edges_t edges;
        logic left_ok;
        logic right_ok;
        logic down_ok;
        shape_idx_t next_idx;

        block_boundary boundary_i
        (
                .pos_x (pos_x),
                .pos_y (pos_y),
                .piece (piece),
                .edges (edges)
        );

        // limit checks skip empty rows and columns
        always_comb
        begin
                left_ok = 1'b1;
                right_ok = 1'b1;
                down_ok = 1'b1;
                for (int i = 0; i < 4; i++)
                begin
                        if (edges.left[i] != NO_EDGE &&
                            11'(edges.left[i]) < 11'(FIELD_LEFT) + 11'(CELL))
                                left_ok = 1'b0;
                        if (edges.right[i] != NO_EDGE &&
                            11'(edges.right[i]) + 11'(2 * CELL) > 11'(FIELD_RIGHT))
                                right_ok = 1'b0;
                        if (edges.bottom[i] != NO_EDGE &&
                            11'(edges.bottom[i]) + 11'(2 * CELL) > 11'(FIELD_BOTTOM))
                                down_ok = 1'b0;
                end
        end

        assign next_idx = (shape_idx == shape_idx_t'(NUM_SHAPES - 1)) ? '0
                                                                      : shape_idx + 1'b1;

        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                begin
                        pos_x <= SPAWN_X;
                        pos_y <= SPAWN_Y;
                        piece <= SHAPES[0];
                        shape_idx <= '0;
                        landing <= 1'b0;
                end
                else
                begin
                        landing <= 1'b0;
                        if (cmd.step_down)
                        begin
                                if (down_ok)
                                        pos_y <= pos_y + CELL;
                                else
                                begin
                                        // floor reached so respawn with next shape
                                        landing <= 1'b1;
                                        pos_x <= SPAWN_X;
                                        pos_y <= SPAWN_Y;
                                        shape_idx <= next_idx;
                                        piece <= SHAPES[next_idx];
                                end
                        end
                        else if (cmd.step_left && left_ok)
                                pos_x <= pos_x - CELL;
                        else if (cmd.step_right && right_ok)
                                pos_x <= pos_x + CELL;
                        // blocked side steps just drop out
                end
        end

endmodule

// ==== source/piece_pkg.sv ====
package piece_pkg;

        import geom_pkg::*;

        // bit 4r+c is row r, column c
        typedef union packed
        {
                logic [15:0] cells;
                logic [3:0][3:0] rows; // rows[r][c]
        } piece_cells_u;

        typedef logic [2:0] shape_idx_t;

        localparam int NUM_SHAPES = 7;

        // I, O, T, S, Z, J, L against row 0 and column 0
        localparam piece_cells_u SHAPES [NUM_SHAPES] = '{
                16'h000F,
                16'h0033,
                16'h0027,
                16'h0036,
                16'h0063,
                16'h0071,
                16'h0074
        };

        typedef struct packed
        {
                coord_t [3:0] bottom; // per column
                coord_t [3:0] left;   // per row
                coord_t [3:0] right;  // per row
        } edges_t;

        typedef struct packed
        {
                logic left;
                logic right;
                logic down;
        } buttons_t;

        // one-hot, one cycle
        typedef struct packed
        {
                logic step_left;
                logic step_right;
                logic step_down;
        } move_cmd_t;

        localparam int FALL_TICKS = 64;
        localparam int FALL_W = $clog2(FALL_TICKS);

endpackage

// ==== source/piece_report.sv ====
`timescale 1ns/1ps

module piece_report
        import geom_pkg::*;
        import piece_pkg::*;
(
        input  logic            clk,
        input  logic            arst_n,
        input  coord_t          pos_x,
        input  coord_t          pos_y,
        input  piece_cells_u    piece,
        input  shape_idx_t      shape_idx,
        input  logic            landing,
        output coord_t          out_x,
        output coord_t          out_y,
        output logic [3:0][3:0] out_rows,
        output shape_idx_t      out_shape,
        output logic            landed,
        output logic [7:0]      land_count
);

        // status for the display side
        always_ff @(posedge clk)
        begin
                out_x <= pos_x;
                out_y <= pos_y;
                out_rows <= piece.rows; // row nibbles for drawing
                out_shape <= shape_idx;
        end

        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                begin
                        landed <= 1'b0;
                        land_count <= '0;
                end
                else
                begin
                        landed <= landing;
                        if (landing)
                                land_count <= land_count + 1'b1; // wraps at 256
                end
        end

endmodule

// ==== source/tetris_drop_top.sv ====
`timescale 1ns/1ps

module tetris_drop_top
        import geom_pkg::*;
        import piece_pkg::*;
(
        input  logic            clk,
        input  logic            arst_n,
        input  buttons_t        buttons,
        input  logic            fall_en,
        output coord_t          out_x,
        output coord_t          out_y,
        output logic [3:0][3:0] out_rows,
        output shape_idx_t      out_shape,
        output logic            landed,
        output logic [7:0]      land_count
);

        move_cmd_t cmd;
        coord_t pos_x;
        coord_t pos_y;
        piece_cells_u piece;
        shape_idx_t shape_idx;
        logic landing;

        move_request request_i
        (
                .clk     (clk),
                .arst_n  (arst_n),
                .buttons (buttons),
                .fall_en (fall_en),
                .cmd     (cmd)
        );

        piece_mover mover_i
        (
                .clk       (clk),
                .arst_n    (arst_n),
                .cmd       (cmd),
                .pos_x     (pos_x),
                .pos_y     (pos_y),
                .piece     (piece),
                .shape_idx (shape_idx),
                .landing   (landing)
        );

        piece_report report_i
        (
                .clk        (clk),
                .arst_n     (arst_n),
                .pos_x      (pos_x),
                .pos_y      (pos_y),
                .piece      (piece),
                .shape_idx  (shape_idx),
                .landing    (landing),
                .out_x      (out_x),
                .out_y      (out_y),
                .out_rows   (out_rows),
                .out_shape  (out_shape),
                .landed     (landed),
                .land_count (land_count)
        );

endmodule

// ==== sources.f ====
source/geom_pkg.sv
source/piece_pkg.sv
source/move_request.sv
source/block_boundary.sv
source/piece_mover.sv
source/piece_report.sv
source/tetris_drop_top.sv
testbench/tetris_drop_assert.sv
testbench/tetris_drop_tb.sv

// ==== testbench/tetris_drop_assert.sv ====
`timescale 1ns/1ps

module tetris_drop_assert
        import geom_pkg::*;
        import piece_pkg::*;
(
        input logic         clk,
        input logic         arst_n,
        input move_cmd_t    cmd,
        input coord_t       pos_x,
        input coord_t       pos_y,
        input piece_cells_u piece,
        input logic         landed,
        input logic [7:0]   land_count
);

        logic cells_inside;

        // every occupied cell within the field
        always_comb
        begin
                cells_inside = 1'b1;
                for (int r = 0; r < 4; r++)
                begin
                        for (int c = 0; c < 4; c++)
                        begin
                                if (piece.cells[4*r + c] &&
                                    (int'(pos_x) + int'(CELL) * c < int'(FIELD_LEFT) ||
                                     int'(pos_x) + int'(CELL) * (c + 1) > int'(FIELD_RIGHT) ||
                                     int'(pos_y) + int'(CELL) * (r + 1) > int'(FIELD_BOTTOM)))
                                        cells_inside = 1'b0;
                        end
                end
        end

        cmd_one_hot: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(cmd))
                else $error("cmd has more than one step bit set");

        landed_single: assert property (@(posedge clk) disable iff (!arst_n)
                $past(landed) |-> !landed)
                else $error("landed held for more than one cycle");

        count_with_landed: assert property (@(posedge clk) disable iff (!arst_n)
                land_count != $past(land_count) |-> landed)
                else $error("land_count changed without landed");

        piece_in_field: assert property (@(posedge clk) disable iff (!arst_n) cells_inside)
                else $error("piece cell outside the field");

endmodule

// mover side checks cmd and cells, report side checks the landing outputs
bind piece_mover tetris_drop_assert mover_assert_i
(
        .clk        (clk),
        .arst_n     (arst_n),
        .cmd        (cmd),
        .pos_x      (pos_x),
        .pos_y      (pos_y),
        .piece      (piece),
        .landed     (1'b0),
        .land_count (8'h00)
);

bind piece_report tetris_drop_assert report_assert_i
(
        .clk        (clk),
        .arst_n     (arst_n),
        .cmd        ('0),
        .pos_x      (pos_x),
        .pos_y      (pos_y),
        .piece      (piece),
        .landed     (landed),
        .land_count (land_count)
);

// ==== testbench/tetris_drop_tb.sv ====
`timescale 1ns/1ps

module tetris_drop_tb
        import geom_pkg::*;
        import piece_pkg::*;
();

        localparam int cell_px = int'(CELL);
        localparam int left_px = int'(FIELD_LEFT);
        localparam int right_px = int'(FIELD_RIGHT);
        localparam int bottom_px = int'(FIELD_BOTTOM);

        // I, O, T, S, Z, J, L
        localparam logic [15:0] shape_table [7] = '{
                16'h000F, 16'h0033, 16'h0027, 16'h0036, 16'h0063, 16'h0071, 16'h0074
        };

        logic clk;
        logic arst_n;
        buttons_t buttons;
        logic fall_en;
        coord_t out_x;
        coord_t out_y;
        logic [3:0][3:0] out_rows;
        shape_idx_t out_shape;
        logic landed;
        logic [7:0] land_count;

        logic [31:0] lfsr;
        int m_x;
        int m_y;
        int m_shape;
        int m_count;
        int errors = 0;
        int test_no = 0;
        int bad_tests = 0;
        int test_base = 0;
        int landed_seen;
        int delay;
        int sel;
        int gap;
        int min_c;
        int max_c;

        tetris_drop_top dut_i
        (
                .clk        (clk),
                .arst_n     (arst_n),
                .buttons    (buttons),
                .fall_en    (fall_en),
                .out_x      (out_x),
                .out_y      (out_y),
                .out_rows   (out_rows),
                .out_shape  (out_shape),
                .landed     (landed),
                .land_count (land_count)
        );

        initial
        begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // taps 32 22 2 1
        endfunction

        task automatic random_bits(input int n, output int value);
                value = 0;
                for (int i = 0; i < n; i++)
                begin
                        lfsr = lfsr_next(lfsr);
                        value = (value << 1) | int'(lfsr[0]);
                end
        endtask

        function automatic int low_row(input logic [15:0] cells, input int c);
                int found;
                found = -1;
                for (int r = 0; r < 4; r++)
                        if (cells[4*r + c])
                                found = r;
                return found;
        endfunction

        function automatic int left_col(input logic [15:0] cells, input int r);
                int found;
                found = -1;
                for (int c = 3; c >= 0; c--)
                        if (cells[4*r + c])
                                found = c;
                return found;
        endfunction

        function automatic int right_col(input logic [15:0] cells, input int r);
                int found;
                found = -1;
                for (int c = 0; c < 4; c++)
                        if (cells[4*r + c])
                                found = c;
                return found;
        endfunction

        // dir 0 left, 1 right, 2 down
        function automatic bit step_allowed(input int dir, input int x, input int y,
                                            input logic [15:0] cells);
                bit ok;
                int lc;
                int rc;
                int br;
                ok = 1'b1;
                for (int i = 0; i < 4; i++)
                begin
                        lc = left_col(cells, i);
                        rc = right_col(cells, i);
                        br = low_row(cells, i);
                        if (dir == 0 && lc >= 0 && x + cell_px * lc - cell_px < left_px)
                                ok = 1'b0;
                        if (dir == 1 && rc >= 0 && x + cell_px * rc + 2 * cell_px > right_px)
                                ok = 1'b0;
                        if (dir == 2 && br >= 0 && y + cell_px * br + 2 * cell_px > bottom_px)
                                ok = 1'b0;
                end
                return ok;
        endfunction

        task automatic check_val(input string name, input logic [15:0] got,
                                 input logic [15:0] exp);
                assert (got == exp)
                else
                begin
                        $display("error: %s is %h, expected %h", name, got, exp);
                        errors++;
                end
        endtask

        task automatic check_flag(input bit ok, input string what);
                assert (ok)
                else
                begin
                        $display("%s", what);
                        errors++;
                end
        endtask

        // hold 4 cycles, release 4, note landed and first position change
        task automatic press(input int btn);
                logic [19:0] old_pos;
                old_pos = {out_x, out_y};
                landed_seen = 0;
                delay = -1;
                @(negedge clk);
                case (btn)
                        0: buttons.left = 1'b1;
                        1: buttons.right = 1'b1;
                        default: buttons.down = 1'b1;
                endcase
                for (int n = 1; n <= 8; n++)
                begin
                        @(negedge clk);
                        if (n == 4)
                                buttons = '0;
                        if (landed)
                                landed_seen++;
                        if (delay < 0 && {out_x, out_y} != old_pos)
                                delay = n - 1; // edges after the sampling edge
                end
        endtask

        task automatic compare_model();
                check_val("out_x", 16'(out_x), 16'(m_x));
                check_val("out_y", 16'(out_y), 16'(m_y));
                check_val("out_rows", 16'(out_rows), shape_table[m_shape]);
                check_val("out_shape", 16'(out_shape), 16'(m_shape));
                check_val("land_count", 16'(land_count), 16'(m_count));
        endtask

        task automatic model_press(input int btn);
                bit allowed;
                allowed = step_allowed(btn, m_x, m_y, shape_table[m_shape]);
                press(btn);
                if (allowed)
                begin
                        case (btn)
                                0: m_x -= cell_px;
                                1: m_x += cell_px;
                                default: m_y += cell_px;
                        endcase
                end
                else if (btn == 2)
                begin
                        m_x = int'(SPAWN_X); // landing respawns with next shape
                        m_y = int'(SPAWN_Y);
                        m_shape = (m_shape + 1) % 7;
                        m_count = (m_count + 1) % 256;
                end
                check_val("landed pulses", 16'(landed_seen),
                          (btn == 2 && !allowed) ? 16'd1 : 16'd0);
                compare_model();
        endtask

        task automatic wait_fall();
                coord_t old_y;
                int cycles;
                old_y = out_y;
                cycles = 0;
                while (out_y == old_y && cycles < FALL_TICKS + 10)
                begin
                        @(negedge clk);
                        cycles++;
                end
                check_flag(out_y != old_y, "timeout: out_y did not rise under gravity");
        endtask

        task automatic end_test(input string name);
                test_no++;
                if (errors == test_base)
                        $display("test %0d %s: ok", test_no, name);
                else
                begin
                        bad_tests++;
                        $display("test %0d %s: %0d errors", test_no, name, errors - test_base);
                end
                test_base = errors;
        endtask

        initial
        begin
                arst_n = 1'b0;
                buttons = '0;
                fall_en = 1'b0;
                lfsr = 32'h8b3f_0b56;
                m_x = int'(SPAWN_X);
                m_y = int'(SPAWN_Y);
                m_shape = 0;
                m_count = 0;
                repeat (16) @(posedge clk);
                @(negedge clk);
                arst_n = 1'b1;
                @(negedge clk);

                compare_model();
                check_val("landed", 16'(landed), 16'd0);
                end_test("reset state");

                model_press(0);
                check_val("out_x latency", 16'(delay), 16'd5);
                model_press(1);
                check_val("out_x latency", 16'(delay), 16'd5);
                end_test("single side steps");

                min_c = 3;
                max_c = 0;
                for (int r = 0; r < 4; r++)
                begin
                        if (left_col(shape_table[m_shape], r) >= 0 &&
                            left_col(shape_table[m_shape], r) < min_c)
                                min_c = left_col(shape_table[m_shape], r);
                        if (right_col(shape_table[m_shape], r) > max_c)
                                max_c = right_col(shape_table[m_shape], r);
                end
                repeat (12) model_press(0);
                check_val("left edge", 16'(int'(out_x) + cell_px * min_c), 16'(left_px));
                repeat (12) model_press(1);
                check_val("right edge", 16'(int'(out_x) + cell_px * (max_c + 1)),
                          16'(right_px));
                end_test("side walls");

                for (int k = 0; k < 30 && step_allowed(2, m_x, m_y, shape_table[m_shape]); k++)
                        model_press(2);
                check_flag(!step_allowed(2, m_x, m_y, shape_table[m_shape]),
                           "piece did not reach the floor within 30 down presses");
                model_press(2);
                end_test("floor landing");

                @(negedge clk);
                fall_en = 1'b1;
                repeat (2)
                begin
                        wait_fall();
                        m_y += cell_px;
                        compare_model();
                end
                @(negedge clk);
                fall_en = 1'b0;
                end_test("gravity");

                for (int n = 0; n < 300; n++)
                begin
                        random_bits(2, sel);
                        random_bits(3, gap);
                        repeat (gap) @(negedge clk);
                        model_press(sel == 3 ? 2 : sel); // down twice as likely
                end
                end_test("random presses");

                $display("tests %0d, failing %0d, errors %0d", test_no, bad_tests, errors);
                if (errors == 0)
                        $display("Test passed");
                else
                        $display("Test failed");
                $finish;
        end

endmodule
